//--- include/mgmt_params.svh
`ifndef MGMT_PARAMS_SVH
`define MGMT_PARAMS_SVH

// Serial clock half periods in aclk cycles
`define MDC_DIV 4
`define EE_SK_DIV 4

// Frame lengths in bits
`define MDIO_PREAMBLE 32
`define MDIO_FRAME_LEN 64 // Preamble plus 32-bit management frame
`define EE_CMD_LEN 11 // Start, opcode, 8-bit address
`define EE_DATA_LEN 16

// Register byte offsets
`define REG_EERD 16'h0014
`define REG_MDIC 16'h0020
`define REG_ICR 16'h00C0
`define REG_IMS 16'h00D0
`define REG_IMC 16'h00D8

// ICR cause bits
`define ICR_MDAC 9
`define ICR_PHYINT 12

`endif

//--- hdl/mgmt_pkg.sv
package mgmt_pkg;

	// EERD as written by the host
	typedef struct packed {
		logic [15:0] rsvd_hi;
		logic [7:0] addr; // EEPROM word address
		logic [6:0] rsvd_lo;
		logic start;
	} eerd_cmd_t;

	// EERD as read back
	typedef struct packed {
		logic [15:0] data; // Word read from EEPROM
		logic [10:0] rsvd_mid;
		logic done;
		logic [3:0] rsvd_lo;
	} eerd_resp_t;

	// One register word seen as command on write and response on read
	typedef union packed {
		eerd_cmd_t cmd;
		eerd_resp_t resp;
	} eerd_u;

endpackage

//--- hdl/mdio_master.sv
`include "mgmt_params.svh"

module mdio_master (
	input logic aclk,
	input logic rst_i,
	input logic req_i,
	input logic [1:0] op_i,
	input logic [4:0] phy_addr_i,
	input logic [4:0] reg_addr_i,
	input logic [15:0] wdata_i,
	output logic ack_o,
	output logic [15:0] rdata_o,
	output logic mdc_o,
	input logic mdio_i,
	output logic mdio_o,
	output logic mdio_oe_o
);
	localparam int PRE = `MDIO_PREAMBLE;
	localparam int FRAME_LEN = `MDIO_FRAME_LEN;
	localparam int CNT_W = $clog2(FRAME_LEN);
	localparam int DIV_W = $clog2(`MDC_DIV + 1);

	logic run;
	logic start;
	logic tick;
	logic rd_op;
	logic [DIV_W-1:0] div_cnt;
	logic [CNT_W-1:0] bit_cnt;
	logic [CNT_W-1:0] nxt_cnt;
	logic [31:0] tx_sr; // Start, op, addresses, TA, data

	assign start = !run && !ack_o && req_i;
	assign tick = (div_cnt == DIV_W'(`MDC_DIV - 1));
	assign nxt_cnt = bit_cnt + 1'b1;

	always_ff @(posedge aclk) begin
		if (rst_i) begin
			run <= 1'b0;
			ack_o <= 1'b0;
			mdc_o <= 1'b0;
			mdio_o <= 1'b1;
			mdio_oe_o <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
		end else if (!run) begin
			if (ack_o && !req_i) begin
				ack_o <= 1'b0;
			end else if (start) begin
				run <= 1'b1;
				div_cnt <= '0;
				bit_cnt <= '0;
				mdio_o <= 1'b1; // First preamble bit
				mdio_oe_o <= 1'b1;
			end
		end else if (tick) begin
			div_cnt <= '0;
			mdc_o <= !mdc_o;
			if (mdc_o) begin // Falling MDC edge
				if (bit_cnt == CNT_W'(FRAME_LEN - 1)) begin
					run <= 1'b0;
					ack_o <= 1'b1;
					mdio_o <= 1'b1;
					mdio_oe_o <= 1'b0;
				end else begin
					bit_cnt <= nxt_cnt;
					if (nxt_cnt >= CNT_W'(PRE))
						mdio_o <= tx_sr[31];
					if (rd_op && nxt_cnt == CNT_W'(PRE + 14))
						mdio_oe_o <= 1'b0; // Release at turnaround
				end
			end
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	always_ff @(posedge aclk) begin
		if (start) begin
			tx_sr <= {2'b01, op_i, phy_addr_i, reg_addr_i, 2'b10, wdata_i};
			rd_op <= (op_i == 2'b10);
		end else if (run && tick) begin
			if (mdc_o && nxt_cnt >= CNT_W'(PRE))
				tx_sr <= {tx_sr[30:0], 1'b0};
			// PHY data sampled on rising MDC
			if (!mdc_o && rd_op && bit_cnt >= CNT_W'(PRE + 16))
				rdata_o <= {rdata_o[14:0], mdio_i};
		end
	end

endmodule

//--- hdl/eeprom_reader.sv
`include "mgmt_params.svh"

module eeprom_reader (
	input logic aclk,
	input logic rst_i,
	input logic req_i,
	input mgmt_pkg::eerd_u cmd_i,
	output logic ack_o,
	output mgmt_pkg::eerd_u resp_o,
	output logic ee_sk_o,
	output logic ee_cs_o,
	output logic ee_di_o,
	input logic ee_do_i
);
	localparam int CMD_LEN = `EE_CMD_LEN;
	localparam int NBITS = `EE_CMD_LEN + `EE_DATA_LEN;
	localparam int CNT_W = $clog2(NBITS);
	localparam int DIV_W = $clog2(`EE_SK_DIV + 1);

	logic run;
	logic start;
	logic tick;
	logic last;
	logic [DIV_W-1:0] div_cnt;
	logic [CNT_W-1:0] bit_cnt; // One count per SK period
	logic [CMD_LEN-1:0] tx_sr;
	logic [15:0] rx_sr;

	assign start = !run && !ack_o && req_i;
	assign tick = (div_cnt == DIV_W'(`EE_SK_DIV - 1));
	assign last = (bit_cnt == CNT_W'(NBITS - 1));
	assign ee_di_o = tx_sr[CMD_LEN-1];

	always_ff @(posedge aclk) begin
		if (rst_i) begin
			run <= 1'b0;
			ack_o <= 1'b0;
			ee_cs_o <= 1'b0;
			ee_sk_o <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
			tx_sr <= '0;
		end else if (!run) begin
			if (ack_o && !req_i) begin
				ack_o <= 1'b0;
			end else if (start) begin
				run <= 1'b1;
				ee_cs_o <= 1'b1;
				div_cnt <= '0;
				bit_cnt <= '0;
				tx_sr <= {3'b110, cmd_i.cmd.addr}; // Start bit and READ opcode
			end
		end else if (tick) begin
			div_cnt <= '0;
			ee_sk_o <= !ee_sk_o;
			if (ee_sk_o) begin // Falling SK edge
				tx_sr <= {tx_sr[CMD_LEN-2:0], 1'b0};
				if (last) begin
					run <= 1'b0;
					ack_o <= 1'b1;
					ee_cs_o <= 1'b0;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// Data bits taken on falling SK after the command
	always_ff @(posedge aclk) begin
		if (run && tick && ee_sk_o && bit_cnt >= CNT_W'(CMD_LEN)) begin
			rx_sr <= {rx_sr[14:0], ee_do_i};
			if (last) begin
				resp_o <= '0;
				resp_o.resp.data <= {rx_sr[14:0], ee_do_i};
				resp_o.resp.done <= 1'b1;
			end
		end
	end

endmodule

//--- hdl/mgmt_regs.sv
`include "mgmt_params.svh"

module mgmt_regs (
	input logic aclk,
	input logic rst_i,
	input logic reg_req_i,
	input logic reg_we_i,
	input logic [15:0] reg_addr_i,
	input logic [31:0] reg_wdata_i,
	output logic reg_ack_o,
	output logic [31:0] reg_rdata_o,
	output logic intr_o,
	input logic phy_int_i,
	output logic mdio_req_o,
	output logic [1:0] mdio_op_o,
	output logic [4:0] mdio_phy_addr_o,
	output logic [4:0] mdio_reg_addr_o,
	output logic [15:0] mdio_wdata_o,
	input logic mdio_ack_i,
	input logic [15:0] mdio_rdata_i,
	output logic ee_req_o,
	output mgmt_pkg::eerd_u ee_cmd_o,
	input logic ee_ack_i,
	input mgmt_pkg::eerd_u ee_resp_i
);
	import mgmt_pkg::*;

	logic acc;
	logic wr_mdic;
	logic wr_eerd;
	logic rd_icr;
	logic wr_ims;
	logic wr_imc;
	logic mdio_done;
	logic ee_done;
	logic mdic_r;
	logic [2:0] phy_int_sync; // Two sync stages and edge history
	logic [31:0] icr_q;
	logic [31:0] ims_q;
	logic [31:0] icr_set;
	eerd_u eerd_q;
	eerd_u wr_word;

	assign acc = reg_req_i && !reg_ack_o; // Access lands as ack rises
	assign wr_word = reg_wdata_i;
	assign mdio_done = mdio_req_o && mdio_ack_i;
	assign ee_done = ee_req_o && ee_ack_i;

	// Writes are dropped while the worker is busy
	assign wr_mdic = acc && reg_we_i && reg_addr_i == `REG_MDIC && !mdio_req_o && !mdio_ack_i;
	assign wr_eerd = acc && reg_we_i && reg_addr_i == `REG_EERD && wr_word.cmd.start &&
		!ee_req_o && !ee_ack_i;
	assign rd_icr = acc && !reg_we_i && reg_addr_i == `REG_ICR;
	assign wr_ims = acc && reg_we_i && reg_addr_i == `REG_IMS;
	assign wr_imc = acc && reg_we_i && reg_addr_i == `REG_IMC;

	always_comb begin
		icr_set = '0;
		icr_set[`ICR_MDAC] = mdio_done;
		icr_set[`ICR_PHYINT] = phy_int_sync[1] && !phy_int_sync[2];
	end

	always_ff @(posedge aclk) begin
		if (rst_i)
			reg_ack_o <= 1'b0;
		else
			reg_ack_o <= reg_req_i;
	end

	always_ff @(posedge aclk) begin
		if (acc) begin
			case (reg_addr_i)
				`REG_MDIC: reg_rdata_o <= {3'b000, mdic_r, mdio_op_o, mdio_phy_addr_o,
					mdio_reg_addr_o, mdio_wdata_o};
				`REG_EERD: reg_rdata_o <= eerd_q;
				`REG_ICR: reg_rdata_o <= icr_q;
				`REG_IMS: reg_rdata_o <= ims_q;
				default: reg_rdata_o <= '0;
			endcase
		end
	end

	// MDIC data field doubles as read result
	always_ff @(posedge aclk) begin
		if (rst_i) begin
			mdio_req_o <= 1'b0;
			mdic_r <= 1'b0;
			mdio_op_o <= '0;
			mdio_phy_addr_o <= '0;
			mdio_reg_addr_o <= '0;
			mdio_wdata_o <= '0;
		end else if (wr_mdic) begin
			mdio_req_o <= 1'b1;
			mdic_r <= 1'b0;
			mdio_op_o <= reg_wdata_i[27:26];
			mdio_phy_addr_o <= reg_wdata_i[25:21];
			mdio_reg_addr_o <= reg_wdata_i[20:16];
			mdio_wdata_o <= reg_wdata_i[15:0];
		end else if (mdio_done) begin
			mdio_req_o <= 1'b0;
			mdic_r <= 1'b1;
			if (mdio_op_o == 2'b10)
				mdio_wdata_o <= mdio_rdata_i;
		end
	end

	always_ff @(posedge aclk) begin
		if (rst_i) begin
			ee_req_o <= 1'b0;
			eerd_q <= '0;
		end else if (wr_eerd) begin
			ee_req_o <= 1'b1;
			eerd_q.resp.done <= 1'b0;
		end else if (ee_done) begin
			ee_req_o <= 1'b0;
			eerd_q <= ee_resp_i;
		end
	end

	always_ff @(posedge aclk) begin
		if (wr_eerd)
			ee_cmd_o <= wr_word;
	end

	always_ff @(posedge aclk) begin
		if (rst_i) begin
			phy_int_sync <= '0;
			icr_q <= '0;
			ims_q <= '0;
			intr_o <= 1'b0;
		end else begin
			phy_int_sync <= {phy_int_sync[1:0], phy_int_i};
			icr_q <= (rd_icr ? 32'h0 : icr_q) | icr_set; // New causes survive a read
			if (wr_ims)
				ims_q <= ims_q | reg_wdata_i;
			else if (wr_imc)
				ims_q <= ims_q & ~reg_wdata_i;
			intr_o <= |(icr_q & ims_q);
		end
	end

endmodule

//--- hdl/mgmt_top.sv
module mgmt_top (
	input logic aclk,
	input logic rst_i,
	input logic reg_req_i,
	input logic reg_we_i,
	input logic [15:0] reg_addr_i,
	input logic [31:0] reg_wdata_i,
	output logic reg_ack_o,
	output logic [31:0] reg_rdata_o,
	output logic intr_o,
	input logic phy_int_i,
	output logic mdc_o,
	input logic mdio_i,
	output logic mdio_o,
	output logic mdio_oe_o,
	output logic ee_sk_o,
	output logic ee_cs_o,
	output logic ee_di_o,
	input logic ee_do_i
);
	import mgmt_pkg::*;

	logic mdio_req;
	logic mdio_ack;
	logic [1:0] mdio_op;
	logic [4:0] mdio_phy_addr;
	logic [4:0] mdio_reg_addr;
	logic [15:0] mdio_wdata;
	logic [15:0] mdio_rdata;
	logic ee_req;
	logic ee_ack;
	eerd_u ee_cmd;
	eerd_u ee_resp;

	mgmt_regs u_mgmt_regs (
		.aclk(aclk), .rst_i(rst_i),
		.reg_req_i(reg_req_i), .reg_we_i(reg_we_i),
		.reg_addr_i(reg_addr_i), .reg_wdata_i(reg_wdata_i),
		.reg_ack_o(reg_ack_o), .reg_rdata_o(reg_rdata_o),
		.intr_o(intr_o), .phy_int_i(phy_int_i),
		.mdio_req_o(mdio_req), .mdio_op_o(mdio_op),
		.mdio_phy_addr_o(mdio_phy_addr), .mdio_reg_addr_o(mdio_reg_addr),
		.mdio_wdata_o(mdio_wdata), .mdio_ack_i(mdio_ack), .mdio_rdata_i(mdio_rdata),
		.ee_req_o(ee_req), .ee_cmd_o(ee_cmd), .ee_ack_i(ee_ack), .ee_resp_i(ee_resp)
	);

	mdio_master u_mdio_master (
		.aclk(aclk), .rst_i(rst_i),
		.req_i(mdio_req), .op_i(mdio_op),
		.phy_addr_i(mdio_phy_addr), .reg_addr_i(mdio_reg_addr), .wdata_i(mdio_wdata),
		.ack_o(mdio_ack), .rdata_o(mdio_rdata),
		.mdc_o(mdc_o), .mdio_i(mdio_i), .mdio_o(mdio_o), .mdio_oe_o(mdio_oe_o)
	);

	eeprom_reader u_eeprom_reader (
		.aclk(aclk), .rst_i(rst_i),
		.req_i(ee_req), .cmd_i(ee_cmd), .ack_o(ee_ack), .resp_o(ee_resp),
		.ee_sk_o(ee_sk_o), .ee_cs_o(ee_cs_o), .ee_di_o(ee_di_o), .ee_do_i(ee_do_i)
	);

endmodule

//--- verification/mgmt_asserts.sv
module mgmt_asserts (
	input logic aclk,
	input logic rst_i,
	input logic reg_req_i,
	input logic reg_ack_i,
	input logic mdio_req_i,
	input logic mdio_ack_i,
	input logic ee_req_i,
	input logic ee_ack_i,
	input logic ee_cs_i,
	input logic ee_sk_i,
	input logic mdc_i,
	input logic mdio_oe_i,
	input logic intr_i
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	// Outputs and handshakes idle right after reset
	idle_after_reset: assert property (@(posedge aclk) rst_i |=> !(intr_i || mdio_oe_i ||
		mdc_i || ee_cs_i || ee_sk_i || reg_ack_i || mdio_req_i || mdio_ack_i ||
		ee_req_i || ee_ack_i))
		else begin
			$error("Output or handshake not idle after reset");
			fail_count++;
		end

	mdio_req_held: assert property (@(posedge aclk) disable iff (rst_i)
		mdio_req_i && !mdio_ack_i |=> mdio_req_i)
		else begin
			$error("MDIO request dropped before its ack");
			fail_count++;
		end

	ee_req_held: assert property (@(posedge aclk) disable iff (rst_i)
		ee_req_i && !ee_ack_i |=> ee_req_i)
		else begin
			$error("EEPROM request dropped before its ack");
			fail_count++;
		end

	mdio_ack_held: assert property (@(posedge aclk) disable iff (rst_i)
		mdio_ack_i && mdio_req_i |=> mdio_ack_i)
		else begin
			$error("MDIO ack fell while request still high");
			fail_count++;
		end

	ee_ack_held: assert property (@(posedge aclk) disable iff (rst_i)
		ee_ack_i && ee_req_i |=> ee_ack_i)
		else begin
			$error("EEPROM ack fell while request still high");
			fail_count++;
		end

	ee_cs_needs_req: assert property (@(posedge aclk) disable iff (rst_i)
		!ee_req_i |-> !ee_cs_i)
		else begin
			$error("EEPROM chip select high without a request");
			fail_count++;
		end

	reg_ack_needs_req: assert property (@(posedge aclk) disable iff (rst_i)
		!reg_req_i |=> !reg_ack_i)
		else begin
			$error("Register ack high without a request");
			fail_count++;
		end

endmodule

//--- verification/tb_mgmt.sv
`include "mgmt_params.svh"

module tb_mgmt;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int ACK_LIMIT = 20;
	localparam int POLL_LIMIT = 600; // Register reads per completion poll
	localparam int PHY_HUNT = 0;
	localparam int PHY_START = 1;
	localparam int PHY_HDR = 2;
	localparam int PHY_TA = 3;
	localparam int PHY_DATA = 4;

	logic aclk;
	logic rst_i;
	logic reg_req_i;
	logic reg_we_i;
	logic [15:0] reg_addr_i;
	logic [31:0] reg_wdata_i;
	logic reg_ack_o;
	logic [31:0] reg_rdata_o;
	logic intr_o;
	logic phy_int_i;
	logic mdc_o;
	logic mdio_i;
	logic mdio_o;
	logic mdio_oe_o;
	logic ee_sk_o;
	logic ee_cs_o;
	logic ee_di_o;
	logic ee_do_i;

	logic [31:0] lfsr_q;
	logic [15:0] ee_mem [256];
	logic [15:0] phy_regs [32];
	int errors = 0;
	int checks = 0;
	int test_errs = 0;
	int tests_run = 0;
	int tests_failed = 0;

	// PHY model state
	int phy_state = PHY_HUNT;
	int phy_ones = 0;
	int phy_cnt = 0;
	int phy_frames = 0;
	logic mdc_prev = 1'b0;
	logic [3:0] phy_bit;
	logic [11:0] phy_hdr; // Op, PHY address, register address
	logic [15:0] phy_sr;
	logic [11:0] phy_last_hdr;
	logic [15:0] phy_last_data;

	// EEPROM model state
	logic sk_prev = 1'b0;
	int ee_cnt = 0;
	logic [3:0] ee_bit;
	logic [10:0] ee_sr;

	mgmt_top u_mgmt_top (.*);

	bind mgmt_top mgmt_asserts u_mgmt_asserts (
		.aclk(aclk), .rst_i(rst_i), .reg_req_i(reg_req_i), .reg_ack_i(reg_ack_o),
		.mdio_req_i(mdio_req), .mdio_ack_i(mdio_ack), .ee_req_i(ee_req), .ee_ack_i(ee_ack),
		.ee_cs_i(ee_cs_o), .ee_sk_i(ee_sk_o), .mdc_i(mdc_o), .mdio_oe_i(mdio_oe_o),
		.intr_i(intr_o)
	);

	initial begin
		aclk = 1'b0;
		forever #50 aclk = ~aclk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	function automatic logic [31:0] mdic_word(input logic r, input logic [1:0] op,
		input logic [4:0] phy, input logic [4:0] ra, input logic [15:0] d);
		return {3'b000, r, op, phy, ra, d};
	endfunction

	function automatic logic [31:0] eerd_start_word(input logic [7:0] addr);
		return {16'h0000, addr, 7'h00, 1'b1};
	endfunction

	function automatic logic [31:0] eerd_done_word(input logic [15:0] d);
		return {d, 11'h000, 1'b1, 4'h0};
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else begin
			$display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic abort_run(input string what);
		$display("Timeout at %0t ns: %s never happened", $time, what);
		$display("*** TEST FAILED ***");
		$finish;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors != test_errs) begin
			tests_failed++;
			$display("Test %0d %s: failed with %0d errors", tests_run, name,
				errors - test_errs);
		end else begin
			$display("Test %0d %s: ok", tests_run, name);
		end
		test_errs = errors;
	endtask

	// Four-phase host access entered and left on a falling edge
	task automatic reg_access(input logic we, input logic [15:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int n;
		n = 0;
		rdata = '0;
		reg_req_i = 1'b1;
		reg_we_i = we;
		reg_addr_i = addr;
		reg_wdata_i = wdata;
		@(negedge aclk);
		while (!reg_ack_o && n < ACK_LIMIT) begin
			n++;
			@(negedge aclk);
		end
		if (!reg_ack_o) begin
			abort_run("register ack rise");
		end else begin
			rdata = reg_rdata_o;
			reg_req_i = 1'b0;
			n = 0;
			@(negedge aclk);
			while (reg_ack_o && n < ACK_LIMIT) begin
				n++;
				@(negedge aclk);
			end
			if (reg_ack_o)
				abort_run("register ack fall");
		end
	endtask

	task automatic reg_write(input logic [15:0] addr, input logic [31:0] wdata);
		logic [31:0] unused;
		reg_access(1'b1, addr, wdata, unused);
	endtask

	task automatic reg_read(input logic [15:0] addr, output logic [31:0] rdata);
		reg_access(1'b0, addr, 32'h0, rdata);
	endtask

	task automatic poll_done(input logic [15:0] addr, input int bit_pos,
		output logic [31:0] val);
		int n;
		n = 0;
		reg_read(addr, val);
		while (!val[bit_pos] && n < POLL_LIMIT) begin
			n++;
			reg_read(addr, val);
		end
		if (!val[bit_pos])
			abort_run("worker completion");
	endtask

	task automatic wait_intr(input logic level);
		int n;
		n = 0;
		while (intr_o !== level && n < ACK_LIMIT) begin
			n++;
			@(negedge aclk);
		end
		if (intr_o !== level)
			abort_run("interrupt output change");
	endtask

	// PHY model sees MDC edges on falling aclk
	always @(negedge aclk) begin
		if (rst_i) begin
			phy_state = PHY_HUNT;
			phy_ones = 0;
			mdio_i <= 1'b1;
		end else if (!mdc_o && mdc_prev && phy_state == PHY_DATA &&
			phy_hdr[11:10] == 2'b10) begin
			phy_bit = 4'(15 - phy_cnt);
			mdio_i <= phy_regs[phy_hdr[4:0]][phy_bit];
		end else if (mdc_o && !mdc_prev) begin
			if (phy_state == PHY_TA || phy_state == PHY_DATA) // Released on reads
				check_value("MDIO output enable", 32'(mdio_oe_o),
					32'(phy_hdr[11:10] != 2'b10));
			case (phy_state)
				PHY_HUNT: begin
					if (!mdio_o && phy_ones >= `MDIO_PREAMBLE)
						phy_state = PHY_START;
					phy_ones = mdio_o ? phy_ones + 1 : 0;
				end
				PHY_START: begin
					phy_state = mdio_o ? PHY_HDR : PHY_HUNT;
					phy_cnt = 0;
				end
				PHY_HDR: begin
					phy_hdr = {phy_hdr[10:0], mdio_o};
					phy_cnt++;
					if (phy_cnt == 12) begin
						phy_state = PHY_TA;
						phy_cnt = 0;
					end
				end
				PHY_TA: begin
					phy_cnt++;
					if (phy_cnt == 2) begin
						phy_state = PHY_DATA;
						phy_cnt = 0;
					end
				end
				default: begin
					phy_sr = {phy_sr[14:0], mdio_o};
					phy_cnt++;
					if (phy_cnt == 16) begin
						if (phy_hdr[11:10] == 2'b01)
							phy_regs[phy_hdr[4:0]] = phy_sr;
						phy_last_hdr = phy_hdr;
						phy_last_data = phy_regs[phy_hdr[4:0]];
						phy_frames++;
						phy_state = PHY_HUNT;
						phy_ones = 0;
						mdio_i <= 1'b1;
					end
				end
			endcase
		end
		mdc_prev = mdc_o;
	end

	// EEPROM model shifts the command in and data out on rising SK
	always @(negedge aclk) begin
		if (!ee_cs_o) begin
			ee_cnt = 0;
		end else if (ee_sk_o && !sk_prev) begin
			if (ee_cnt < `EE_CMD_LEN) begin
				ee_sr = {ee_sr[9:0], ee_di_o};
			end else begin
				if (ee_cnt == `EE_CMD_LEN)
					check_value("EEPROM start and opcode", 32'(ee_sr[10:8]), 32'h6);
				ee_bit = 4'(`EE_CMD_LEN + `EE_DATA_LEN - 1 - ee_cnt);
				ee_do_i <= ee_mem[ee_sr[7:0]][ee_bit];
			end
			ee_cnt++;
		end
		sk_prev = ee_sk_o;
	end

	task automatic test_reset_state();
		logic [31:0] v;
		check_value("idle outputs",
			32'({intr_o, mdio_oe_o, ee_cs_o, reg_ack_o, mdc_o, ee_sk_o}), 32'h0);
		reg_read(`REG_MDIC, v);
		check_value("MDIC after reset", v, 32'h0);
		reg_read(`REG_EERD, v);
		check_value("EERD after reset", v, 32'h0);
		reg_read(`REG_ICR, v);
		check_value("ICR after reset", v, 32'h0);
		end_test("reset state");
	endtask

	task automatic test_mdio(input logic [1:0] op, input string name);
		logic [4:0] phy;
		logic [4:0] ra;
		logic [15:0] d;
		logic [31:0] v;
		int frames;
		for (int i = 0; i < 4; i++) begin
			phy = 5'(rand_bits(5));
			ra = 5'(rand_bits(5));
			d = (op == 2'b01) ? 16'(rand_bits(16)) : phy_regs[ra]; // Read expects model value
			frames = phy_frames;
			reg_write(`REG_MDIC, mdic_word(1'b0, op, phy, ra, (op == 2'b01) ? d : 16'h0));
			poll_done(`REG_MDIC, 28, v);
			check_value("MDIC on completion", v, mdic_word(1'b1, op, phy, ra, d));
			check_value("PHY frame count", 32'(phy_frames), 32'(frames + 1));
			check_value("PHY frame header", 32'(phy_last_hdr), 32'({op, phy, ra}));
			check_value("PHY register value", 32'(phy_last_data), 32'(d));
		end
		end_test(name);
	endtask

	task automatic test_eeprom_read();
		logic [7:0] ea;
		logic [31:0] v;
		for (int i = 0; i < 6; i++) begin
			ea = 8'(rand_bits(8));
			reg_write(`REG_EERD, eerd_start_word(ea));
			poll_done(`REG_EERD, 4, v);
			check_value("EERD on completion", v, eerd_done_word(ee_mem[ea]));
		end
		end_test("EEPROM read");
	endtask

	task automatic test_interrupts();
		logic [31:0] v;
		int highs;
		reg_read(`REG_ICR, v); // Causes left over from the MDIO tests
		check_value("ICR before unmask", v, 32'h1 << `ICR_MDAC);
		reg_write(`REG_IMS, (32'h1 << `ICR_MDAC) | (32'h1 << `ICR_PHYINT));
		check_value("intr_o with no pending cause", 32'(intr_o), 32'h0);
		reg_write(`REG_MDIC, mdic_word(1'b0, 2'b01, 5'(rand_bits(5)), 5'(rand_bits(5)),
			16'(rand_bits(16))));
		poll_done(`REG_MDIC, 28, v);
		wait_intr(1'b1);
		reg_read(`REG_ICR, v);
		check_value("ICR after MDIO completion", v, 32'h1 << `ICR_MDAC);
		wait_intr(1'b0);
		reg_read(`REG_ICR, v);
		check_value("ICR after read clear", v, 32'h0);
		phy_int_i = 1'b1;
		repeat (3) @(negedge aclk);
		phy_int_i = 1'b0;
		wait_intr(1'b1);
		reg_read(`REG_ICR, v);
		check_value("ICR after PHY interrupt", v, 32'h1 << `ICR_PHYINT);
		wait_intr(1'b0);
		reg_write(`REG_IMC, 32'h1 << `ICR_MDAC);
		reg_read(`REG_IMS, v);
		check_value("IMS after IMC", v, 32'h1 << `ICR_PHYINT);
		reg_write(`REG_MDIC, mdic_word(1'b0, 2'b10, 5'(rand_bits(5)), 5'(rand_bits(5)), 16'h0));
		poll_done(`REG_MDIC, 28, v);
		highs = 0;
		for (int i = 0; i < 8; i++) begin // Masked cause must stay quiet
			@(negedge aclk);
			if (intr_o)
				highs++;
		end
		check_value("intr_o cycles with cause masked", 32'(highs), 32'h0);
		reg_read(`REG_ICR, v);
		check_value("ICR with cause masked", v, 32'h1 << `ICR_MDAC);
		reg_write(`REG_IMC, 32'h1 << `ICR_PHYINT);
		end_test("interrupts");
	endtask

	task automatic test_side_by_side();
		logic [7:0] ea;
		logic [4:0] phy;
		logic [4:0] ra;
		logic [31:0] v;
		for (int i = 0; i < 3; i++) begin
			ea = 8'(rand_bits(8));
			phy = 5'(rand_bits(5));
			ra = 5'(rand_bits(5));
			reg_write(`REG_EERD, eerd_start_word(ea));
			reg_write(`REG_MDIC, mdic_word(1'b0, 2'b10, phy, ra, 16'h0));
			poll_done(`REG_EERD, 4, v);
			check_value("EERD beside MDIO", v, eerd_done_word(ee_mem[ea]));
			poll_done(`REG_MDIC, 28, v);
			check_value("MDIC beside EEPROM", v, mdic_word(1'b1, 2'b10, phy, ra, phy_regs[ra]));
		end
		end_test("side by side");
	endtask

	initial begin
		int asserts_failed;
		rst_i = 1'b1;
		reg_req_i = 1'b0;
		reg_we_i = 1'b0;
		reg_addr_i = '0;
		reg_wdata_i = '0;
		phy_int_i = 1'b0;
		mdio_i = 1'b1;
		ee_do_i = 1'b0;
		lfsr_q = 32'h7cc1_76ee;
		for (int i = 0; i < 256; i++)
			ee_mem[i] = 16'(rand_bits(16));
		for (int i = 0; i < 32; i++)
			phy_regs[i] = 16'(rand_bits(16));
		repeat (16) @(negedge aclk);
		rst_i = 1'b0;
		test_reset_state();
		test_mdio(2'b01, "MDIO write");
		test_mdio(2'b10, "MDIO read");
		test_eeprom_read();
		test_interrupts();
		test_side_by_side();
		asserts_failed = u_mgmt_top.u_mgmt_asserts.fail_count;
		$display("Tests run %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
			tests_run, tests_failed, checks, errors, asserts_failed);
		if (errors == 0 && asserts_failed == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- list.f
+incdir+include
hdl/mgmt_pkg.sv
hdl/mdio_master.sv
hdl/eeprom_reader.sv
hdl/mgmt_regs.sv
hdl/mgmt_top.sv
verification/mgmt_asserts.sv
verification/tb_mgmt.sv

//--- Bender.yml
package:
  name: mgmt

export_include_dirs:
  - include

sources:
  - files:
      - hdl/mgmt_pkg.sv
      - hdl/mdio_master.sv
      - hdl/eeprom_reader.sv
      - hdl/mgmt_regs.sv
      - hdl/mgmt_top.sv
  - target: test
    files:
      - verification/mgmt_asserts.sv
      - verification/tb_mgmt.sv
